//--- common/pool_pkg.sv
/*
 * Shared definitions for the TCDM pool cluster
 * Cluster sizes, bank and row address split, common data types
 * and helper functions that decode a byte address
 */

package pool_pkg;

  // Cluster dimensions
  localparam int unsigned NUM_TILES  = 4;
  localparam int unsigned NUM_BANKS  = 4;
  localparam int unsigned BANK_WORDS = 64;

  // Word and address widths
  localparam int unsigned DATA_W = 32;
  localparam int unsigned ADDR_W = 32;

  // Address split, from the LSB upward: byte offset, bank select, row
  localparam int unsigned BYTE_OFF_W  = 2;
  localparam int unsigned BANK_SEL_W  = $clog2(NUM_BANKS);
  localparam int unsigned BANK_ADDR_W = $clog2(BANK_WORDS);

  typedef logic [DATA_W-1:0]            data_t;
  typedef logic [ADDR_W-1:0]            addr_t;
  typedef logic [$clog2(NUM_TILES)-1:0] tile_id_t;
  typedef logic [BANK_SEL_W-1:0]        bank_id_t;
  typedef logic [BANK_ADDR_W-1:0]       bank_addr_t;

  // Bank index taken from the word address bits just above the byte offset
  function automatic bank_id_t addr_to_bank(addr_t addr);
    return addr[BYTE_OFF_W +: BANK_SEL_W];
  endfunction

  // Row index inside the bank, anything above the row bits wraps
  function automatic bank_addr_t addr_to_row(addr_t addr);
    return addr[BYTE_OFF_W + BANK_SEL_W +: BANK_ADDR_W];
  endfunction

endpackage : pool_pkg

//--- rtl/tcdm_bank.sv
/*
 * Single-port scratchpad bank with a registered read port
 * Reads return data one cycle after the enable, writes land at the edge
 */

`timescale 1ns/100ps

module tcdm_bank (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic                 en_i,
  input  logic                 we_i,
  input  pool_pkg::bank_addr_t addr_i,
  input  pool_pkg::data_t      wdata_i,
  output pool_pkg::data_t      rdata_o
);

  import pool_pkg::*;

  // Word storage, contents are undefined after reset
  data_t mem_q [BANK_WORDS];
  data_t rdata_q;

  // Write port
  always_ff @(posedge clk_i) begin
    if (en_i && we_i) begin
      mem_q[addr_i] <= wdata_i;
    end
  end

  // Read port, the output register only moves on a read
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rdata_q <= '0;
    end else if (en_i && !we_i) begin
      rdata_q <= mem_q[addr_i];
    end
  end

  assign rdata_o = rdata_q;

  // The crossbar must never enable the bank with an unresolved row or direction
  a_ctrl_known: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    en_i |-> !$isunknown({addr_i, we_i}));

endmodule : tcdm_bank

//--- interconnect/tcdm_arbiter.sv
/*
 * Round-robin arbiter for one TCDM bank
 * Grants the first requesting tile at or after the priority pointer
 */

`timescale 1ns/100ps

module tcdm_arbiter (
  input  logic                                clk_i,
  input  logic                                arst_n_i,
  input  logic [pool_pkg::NUM_TILES-1:0]      req_i,
  output logic [pool_pkg::NUM_TILES-1:0]      gnt_o,
  output pool_pkg::tile_id_t                  gnt_idx_o,
  output logic                                gnt_valid_o
);

  import pool_pkg::*;

  // Tile with the highest priority in the current cycle
  tile_id_t ptr_q;

  // Scan all tiles starting at the pointer and stop at the first requester
  always_comb begin
    tile_id_t cand;
    logic     found;
    found       = 1'b0;
    gnt_o       = '0;
    gnt_idx_o   = '0;
    gnt_valid_o = 1'b0;
    for (int i = 0; i < NUM_TILES; i++) begin
      cand = tile_id_t'((int'(ptr_q) + i) % NUM_TILES);
      if (!found && req_i[cand]) begin
        found        = 1'b1;
        gnt_o[cand]  = 1'b1;
        gnt_idx_o    = cand;
        gnt_valid_o  = 1'b1;
      end
    end
  end

  // Pointer moves one past the winner, so the winner drops to lowest priority
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ptr_q <= '0;
    end else if (gnt_valid_o) begin
      ptr_q <= tile_id_t'((int'(gnt_idx_o) + 1) % NUM_TILES);
    end
  end

  // At most one tile owns the bank in any cycle
  a_gnt_onehot: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $onehot0(gnt_o));

  // A grant never goes to a tile that is not asking for this bank
  a_gnt_req: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (gnt_o & ~req_i) == '0);

endmodule : tcdm_arbiter

//--- interconnect/tcdm_xbar.sv
/*
 * Tile to bank crossbar for the shared TCDM
 * Address decode, one round-robin arbiter per bank, field multiplexing
 * and routing of bank read data back to the granted tile
 */

`timescale 1ns/100ps

module tcdm_xbar (
  input  logic                                           clk_i,
  input  logic                                           arst_n_i,
  // Tile side
  input  logic [pool_pkg::NUM_TILES-1:0]                 tile_req_i,
  input  logic [pool_pkg::NUM_TILES-1:0]                 tile_we_i,
  input  pool_pkg::addr_t [pool_pkg::NUM_TILES-1:0]      tile_addr_i,
  input  pool_pkg::data_t [pool_pkg::NUM_TILES-1:0]      tile_wdata_i,
  output logic [pool_pkg::NUM_TILES-1:0]                 tile_gnt_o,
  output logic [pool_pkg::NUM_TILES-1:0]                 tile_rvalid_o,
  output pool_pkg::data_t [pool_pkg::NUM_TILES-1:0]      tile_rdata_o,
  // Bank side
  output logic [pool_pkg::NUM_BANKS-1:0]                 bank_en_o,
  output logic [pool_pkg::NUM_BANKS-1:0]                 bank_we_o,
  output pool_pkg::bank_addr_t [pool_pkg::NUM_BANKS-1:0] bank_addr_o,
  output pool_pkg::data_t [pool_pkg::NUM_BANKS-1:0]      bank_wdata_o,
  input  pool_pkg::data_t [pool_pkg::NUM_BANKS-1:0]      bank_rdata_i
);

  import pool_pkg::*;

  bank_id_t [NUM_TILES-1:0]                 tile_bank;
  logic     [NUM_BANKS-1:0][NUM_TILES-1:0]  bank_req;
  logic     [NUM_BANKS-1:0][NUM_TILES-1:0]  bank_gnt;
  logic     [NUM_TILES-1:0][NUM_BANKS-1:0]  gnt_by_tile;
  tile_id_t [NUM_BANKS-1:0]                 gnt_idx;
  logic     [NUM_BANKS-1:0]                 gnt_valid;
  // Owner of each bank in the previous cycle, used to steer read data back
  tile_id_t [NUM_BANKS-1:0]                 rsp_idx_q;
  logic     [NUM_BANKS-1:0]                 rsp_valid_q;

  // Each tile asks exactly the bank its address falls into
  always_comb begin
    for (int t = 0; t < NUM_TILES; t++) begin
      tile_bank[t] = addr_to_bank(tile_addr_i[t]);
      for (int b = 0; b < NUM_BANKS; b++) begin
        bank_req[b][t] = tile_req_i[t] && (tile_bank[t] == bank_id_t'(b));
      end
    end
  end

  for (genvar b = 0; b < NUM_BANKS; b++) begin : gen_bank
    tcdm_arbiter i_arb (
      .clk_i       (clk_i       ),
      .arst_n_i    (arst_n_i    ),
      .req_i       (bank_req[b] ),
      .gnt_o       (bank_gnt[b] ),
      .gnt_idx_o   (gnt_idx[b]  ),
      .gnt_valid_o (gnt_valid[b])
    );

    // The winning tile's fields drive the bank port
    assign bank_en_o[b]    = gnt_valid[b];
    assign bank_we_o[b]    = tile_we_i[gnt_idx[b]];
    assign bank_addr_o[b]  = addr_to_row(tile_addr_i[gnt_idx[b]]);
    assign bank_wdata_o[b] = tile_wdata_i[gnt_idx[b]];
  end

  // Fold the per-bank grants into one grant per tile
  always_comb begin
    for (int t = 0; t < NUM_TILES; t++) begin
      for (int b = 0; b < NUM_BANKS; b++) begin
        gnt_by_tile[t][b] = bank_gnt[b][t];
      end
      tile_gnt_o[t] = |gnt_by_tile[t];
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rsp_valid_q <= '0;
      rsp_idx_q   <= '0;
    end else begin
      rsp_valid_q <= gnt_valid;
      rsp_idx_q   <= gnt_idx;
    end
  end

  // Bank outputs of this cycle belong to last cycle's winners
  always_comb begin
    tile_rvalid_o = '0;
    tile_rdata_o  = '0;
    for (int b = 0; b < NUM_BANKS; b++) begin
      if (rsp_valid_q[b]) begin
        tile_rvalid_o[rsp_idx_q[b]] = 1'b1;
        tile_rdata_o[rsp_idx_q[b]]  = bank_rdata_i[b];
      end
    end
  end

  // A tile is never served by two banks at once across the arbiter set
  for (genvar t = 0; t < NUM_TILES; t++) begin : gen_gnt_chk
    a_single_bank: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      $onehot0(gnt_by_tile[t]));
  end

endmodule : tcdm_xbar

//--- tile/tile_port.sv
/*
 * Tile front end between a four-phase req/ack master and the TCDM crossbar
 * One external transaction becomes one granted TCDM access
 */

`timescale 1ns/100ps

module tile_port (
  input  logic            clk_i,
  input  logic            arst_n_i,
  // External four-phase handshake
  input  logic            req_i,
  input  logic            we_i,
  input  pool_pkg::addr_t addr_i,
  input  pool_pkg::data_t wdata_i,
  output logic            ack_o,
  output pool_pkg::data_t rdata_o,
  // Request toward the crossbar
  output logic            tcdm_req_o,
  output logic            tcdm_we_o,
  output pool_pkg::addr_t tcdm_addr_o,
  output pool_pkg::data_t tcdm_wdata_o,
  input  logic            tcdm_gnt_i,
  input  logic            tcdm_rvalid_i,
  input  pool_pkg::data_t tcdm_rdata_i
);

  import pool_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_REQ,
    ST_WAIT,
    ST_ACK
  } state_e;

  state_e state_q;
  // Transaction captured when it leaves IDLE, held until the next one
  logic   we_q;
  addr_t  addr_q;
  data_t  wdata_q;
  data_t  rdata_q;

  always_ff @(posedge clk_i) begin
    if (state_q == ST_IDLE && req_i) begin
      we_q    <= we_i;
      addr_q  <= addr_i;
      wdata_q <= wdata_i;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= ST_IDLE;
      rdata_q <= '0;
    end else begin
      unique case (state_q)
        ST_IDLE: if (req_i)      state_q <= ST_REQ;
        // Request stays up with fixed fields until the bank accepts it
        ST_REQ:  if (tcdm_gnt_i) state_q <= ST_WAIT;
        ST_WAIT: begin
          if (tcdm_rvalid_i) begin
            // Writes also see rvalid but carry no useful data
            if (!we_q) rdata_q <= tcdm_rdata_i;
            state_q <= ST_ACK;
          end
        end
        ST_ACK:  if (!req_i)     state_q <= ST_IDLE;
        default:                 state_q <= ST_IDLE;
      endcase
    end
  end

  assign tcdm_req_o   = (state_q == ST_REQ);
  assign tcdm_we_o    = we_q;
  assign tcdm_addr_o  = addr_q;
  assign tcdm_wdata_o = wdata_q;

  assign ack_o   = (state_q == ST_ACK);
  assign rdata_o = rdata_q;

  // Master must keep req up for the whole access until it sees ack
  a_req_held: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (state_q inside {ST_REQ, ST_WAIT}) |-> req_i);

endmodule : tile_port

//--- rtl/pool_wrap.sv
/*
 * Top level of the TCDM pool cluster
 * Tile ports, the bank crossbar and the scratchpad banks
 */

`timescale 1ns/100ps

module pool_wrap (
  input  logic                                      clk_i,
  input  logic                                      arst_n_i,
  input  logic [pool_pkg::NUM_TILES-1:0]            req_i,
  input  logic [pool_pkg::NUM_TILES-1:0]            we_i,
  input  pool_pkg::addr_t [pool_pkg::NUM_TILES-1:0] addr_i,
  input  pool_pkg::data_t [pool_pkg::NUM_TILES-1:0] wdata_i,
  output logic [pool_pkg::NUM_TILES-1:0]            ack_o,
  output pool_pkg::data_t [pool_pkg::NUM_TILES-1:0] rdata_o
);

  import pool_pkg::*;

  // Tile to crossbar
  logic  [NUM_TILES-1:0] tcdm_req, tcdm_we, tcdm_gnt, tcdm_rvalid;
  addr_t [NUM_TILES-1:0] tcdm_addr;
  data_t [NUM_TILES-1:0] tcdm_wdata, tcdm_rdata;

  // Crossbar to banks
  logic       [NUM_BANKS-1:0] bank_en, bank_we;
  bank_addr_t [NUM_BANKS-1:0] bank_addr;
  data_t      [NUM_BANKS-1:0] bank_wdata, bank_rdata;

  for (genvar t = 0; t < NUM_TILES; t++) begin : gen_tile
    tile_port i_tile_port (
      .clk_i         (clk_i         ),
      .arst_n_i      (arst_n_i      ),
      .req_i         (req_i[t]      ),
      .we_i          (we_i[t]       ),
      .addr_i        (addr_i[t]     ),
      .wdata_i       (wdata_i[t]    ),
      .ack_o         (ack_o[t]      ),
      .rdata_o       (rdata_o[t]    ),
      .tcdm_req_o    (tcdm_req[t]   ),
      .tcdm_we_o     (tcdm_we[t]    ),
      .tcdm_addr_o   (tcdm_addr[t]  ),
      .tcdm_wdata_o  (tcdm_wdata[t] ),
      .tcdm_gnt_i    (tcdm_gnt[t]   ),
      .tcdm_rvalid_i (tcdm_rvalid[t]),
      .tcdm_rdata_i  (tcdm_rdata[t] )
    );
  end

  tcdm_xbar i_xbar (
    .clk_i         (clk_i      ),
    .arst_n_i      (arst_n_i   ),
    .tile_req_i    (tcdm_req   ),
    .tile_we_i     (tcdm_we    ),
    .tile_addr_i   (tcdm_addr  ),
    .tile_wdata_i  (tcdm_wdata ),
    .tile_gnt_o    (tcdm_gnt   ),
    .tile_rvalid_o (tcdm_rvalid),
    .tile_rdata_o  (tcdm_rdata ),
    .bank_en_o     (bank_en    ),
    .bank_we_o     (bank_we    ),
    .bank_addr_o   (bank_addr  ),
    .bank_wdata_o  (bank_wdata ),
    .bank_rdata_i  (bank_rdata )
  );

  for (genvar b = 0; b < NUM_BANKS; b++) begin : gen_bank
    tcdm_bank i_bank (
      .clk_i    (clk_i        ),
      .arst_n_i (arst_n_i     ),
      .en_i     (bank_en[b]   ),
      .we_i     (bank_we[b]   ),
      .addr_i   (bank_addr[b] ),
      .wdata_i  (bank_wdata[b]),
      .rdata_o  (bank_rdata[b])
    );
  end

endmodule : pool_wrap

//--- verification/pool_checker.sv
/*
 * Scoreboard and protocol monitor for the pool cluster testbench
 * Read data compare, four-phase handshake rules and the bank fairness bound
 */

`timescale 1ns/100ps

module pool_checker (
  input  logic                                      clk_i,
  input  logic                                      arst_n_i,
  input  logic [pool_pkg::NUM_TILES-1:0]            req_i,
  input  logic [pool_pkg::NUM_TILES-1:0]            we_i,
  input  pool_pkg::addr_t [pool_pkg::NUM_TILES-1:0] addr_i,
  input  logic [pool_pkg::NUM_TILES-1:0]            ack_i,
  input  pool_pkg::data_t [pool_pkg::NUM_TILES-1:0] rdata_i,
  input  pool_pkg::data_t [pool_pkg::NUM_TILES-1:0] exp_rdata_i,
  output int unsigned                               pass_cnt_o,
  output int unsigned                               fail_cnt_o,
  output int unsigned                               err_cnt_o
);

  import pool_pkg::*;

  int unsigned          pass_cnt = 0;
  int unsigned          fail_cnt = 0;
  int unsigned          err_cnt  = 0;
  logic [NUM_TILES-1:0] req_q;
  logic [NUM_TILES-1:0] ack_q;
  // Tiles whose req is up and whose ack has not risen yet
  logic [NUM_TILES-1:0] pending_q;
  // Same-bank acks of other tiles seen while each request waits
  int unsigned          ahead_q [NUM_TILES];

  assign pass_cnt_o = pass_cnt;
  assign fail_cnt_o = fail_cnt;
  assign err_cnt_o  = err_cnt;

  task automatic flag_protocol_error(input string msg);
    $display("%s", msg);
    err_cnt++;
  endtask

  // Writes only need to finish, reads must return the word from the file
  task automatic score_transaction(input int t);
    if (we_i[t]) begin
      pass_cnt++;
      $display("[PASS] tile %0d write addr %h", t, addr_i[t]);
    end else if (rdata_i[t] === exp_rdata_i[t]) begin
      pass_cnt++;
      $display("[PASS] tile %0d read addr %h data %h", t, addr_i[t], rdata_i[t]);
    end else begin
      fail_cnt++;
      $display("[FAIL] rdata_o[%0d] got %h expected %h (addr %h)",
               t, rdata_i[t], exp_rdata_i[t], addr_i[t]);
    end
  endtask

  // Bank index sits in byte address bits 3:2
  // Round robin lets at most NUM_TILES-1 other tiles on one bank go first
  task automatic count_ahead(input int u);
    for (int v = 0; v < NUM_TILES; v++) begin
      if (v != u && pending_q[v] && addr_i[v][3:2] == addr_i[u][3:2]) begin
        ahead_q[v]++;
        if (ahead_q[v] > NUM_TILES - 1) begin
          flag_protocol_error($sformatf("Tile %0d saw %0d acks on bank %0d before its own",
                                        v, ahead_q[v], addr_i[v][3:2]));
        end
      end
    end
  endtask

  always @(posedge clk_i) begin
    if (!arst_n_i) begin
      if (ack_i != '0) begin
        flag_protocol_error($sformatf("ack_o is %h during reset while all acks must be low",
                                      ack_i));
      end
      pending_q = '0;
    end else begin
      // New requests first, so an ack in the same cycle already counts against them
      for (int t = 0; t < NUM_TILES; t++) begin
        if (req_i[t] && !req_q[t]) begin
          if (ack_i[t]) begin
            flag_protocol_error($sformatf("Tile %0d raised req before its ack dropped", t));
          end
          pending_q[t] = 1'b1;
          ahead_q[t]   = 0;
        end
      end
      for (int t = 0; t < NUM_TILES; t++) begin
        if (ack_i[t] && !ack_q[t]) begin
          // The edge that raised ack saw the req of the previous sample
          if (!req_q[t]) begin
            flag_protocol_error($sformatf("Tile %0d ack rose while its req was low", t));
          end
          score_transaction(t);
          count_ahead(t);
          pending_q[t] = 1'b0;
        end
        // Ack may only fall once req was seen low
        if (!ack_i[t] && ack_q[t] && req_q[t]) begin
          flag_protocol_error($sformatf("Tile %0d dropped ack while its req was high", t));
        end
      end
    end
    req_q = req_i;
    ack_q = ack_i;
  end

endmodule : pool_checker

//--- verification/tb_pool.sv
/*
 * Testbench top for the TCDM pool cluster
 * Clock, reset, stimulus file, per-tile four-phase drivers with random gaps
 * and a cycle watchdog
 */

`timescale 1ns/100ps

module tb_pool;

  import pool_pkg::*;

  localparam int          MAX_LINES       = 64;
  localparam int          FIELDS          = 6;
  localparam int          END_GROUP       = 'hff;
  localparam int unsigned CYCLES_PER_LINE = NUM_TILES * 3 + 8;

  logic                  clk;
  logic                  arst_n;
  logic [NUM_TILES-1:0]  req;
  logic [NUM_TILES-1:0]  we;
  logic [NUM_TILES-1:0]  ack;
  addr_t [NUM_TILES-1:0] addr;
  data_t [NUM_TILES-1:0] wdata;
  data_t [NUM_TILES-1:0] rdata;
  data_t [NUM_TILES-1:0] exp_rdata;

  // Six words per line: group, tile, we, addr, wdata, expected rdata
  logic [31:0] tests_mem [MAX_LINES*FIELDS];
  int          num_lines;
  int          last_group;
  int          tiles_done;
  logic [15:0] lfsr_q;
  int unsigned cycle_cnt   = 0;
  int unsigned cycle_limit = 0;
  int unsigned pass_cnt;
  int unsigned fail_cnt;
  int unsigned err_cnt;

  pool_wrap u_pool_wrap (
    .clk_i    (clk   ),
    .arst_n_i (arst_n),
    .req_i    (req   ),
    .we_i     (we    ),
    .addr_i   (addr  ),
    .wdata_i  (wdata ),
    .ack_o    (ack   ),
    .rdata_o  (rdata )
  );

  pool_checker u_pool_checker (
    .clk_i       (clk      ),
    .arst_n_i    (arst_n   ),
    .req_i       (req      ),
    .we_i        (we       ),
    .addr_i      (addr     ),
    .ack_i       (ack      ),
    .rdata_i     (rdata    ),
    .exp_rdata_i (exp_rdata),
    .pass_cnt_o  (pass_cnt ),
    .fail_cnt_o  (fail_cnt ),
    .err_cnt_o   (err_cnt  )
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Galois LFSR with taps 0xB400, one step for every bit taken
  function automatic logic [3:0] random_bits(input int n);
    logic [3:0] bits;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      bits   = {bits[2:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 16'hB400) : (lfsr_q >> 1);
    end
    return bits;
  endfunction

  // Zero to three idle cycles, starting and ending on a falling edge
  task automatic random_gap();
    int n;
    n = int'(random_bits(2));
    repeat (n) @(negedge clk);
  endtask

  // Plays this tile's lines of one group in file order
  task automatic run_tile(input int t, input int grp);
    int base;
    for (int i = 0; i < num_lines; i++) begin
      base = i * FIELDS;
      if (int'(tests_mem[base]) == grp && int'(tests_mem[base+1]) == t) begin
        random_gap();
        we[t]        = tests_mem[base+2][0];
        addr[t]      = tests_mem[base+3];
        wdata[t]     = tests_mem[base+4];
        exp_rdata[t] = tests_mem[base+5];
        req[t]       = 1'b1;
        do @(negedge clk); while (!ack[t]);
        random_gap();
        req[t] = 1'b0;
        // Next request waits for the slave to close the handshake
        do @(negedge clk); while (ack[t]);
      end
    end
    tiles_done++;
  endtask

  initial begin
    req       = '0;
    we        = '0;
    addr      = '0;
    wdata     = '0;
    exp_rdata = '0;
    arst_n    = 1'b0;
    lfsr_q    = 16'd35038;
    for (int i = 0; i < MAX_LINES * FIELDS; i++) begin
      tests_mem[i] = 32'(END_GROUP);
    end
    $readmemh("verification/pool_tests.mem", tests_mem);
    num_lines  = 0;
    last_group = -1;
    while (num_lines < MAX_LINES && tests_mem[num_lines*FIELDS] != 32'(END_GROUP)) begin
      if (int'(tests_mem[num_lines*FIELDS]) > last_group) begin
        last_group = int'(tests_mem[num_lines*FIELDS]);
      end
      num_lines++;
    end
    cycle_limit = num_lines * CYCLES_PER_LINE + 100;
    if (num_lines == 0) begin
      $display("No test lines found in verification/pool_tests.mem");
    end
    repeat (8) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    // Tiles of one group run side by side, the group closes when all are idle
    for (int g = 0; g <= last_group; g++) begin
      tiles_done = 0;
      for (int t = 0; t < NUM_TILES; t++) begin
        automatic int tile = t;
        automatic int grp  = g;
        fork
          run_tile(tile, grp);
        join_none
      end
      wait (tiles_done == NUM_TILES);
      @(negedge clk);
    end
    repeat (2) @(negedge clk);
    $display("Summary: %0d passed, %0d failed, %0d protocol errors, %0d lines in file",
             pass_cnt, fail_cnt, err_cnt, num_lines);
    if (num_lines > 0 && fail_cnt == 0 && err_cnt == 0 && pass_cnt == num_lines) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  // Watchdog sized from the number of transactions in the file
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
      $display("Timeout after %0d cycles, not every transaction finished", cycle_cnt);
      $display("TEST FAIL");
      $finish;
    end
  end

endmodule : tb_pool

//--- verification/pool_tests.mem
// Columns: group tile we addr wdata expected_rdata, all hex, expected ignored on writes
// Group ff ends the list
00 0 1 00000004 a5a50001 00000000
01 0 0 00000004 00000000 a5a50001
02 0 1 00000010 10000010 00000000
02 1 1 00000014 10000014 00000000
02 2 1 00000018 10000018 00000000
02 3 1 0000001c 1000001c 00000000
03 0 0 00000014 00000000 10000014
03 1 0 00000018 00000000 10000018
03 2 0 0000001c 00000000 1000001c
03 3 0 00000010 00000000 10000010
04 0 1 00000024 20000024 00000000
04 1 1 00000034 20000034 00000000
04 2 1 00000044 20000044 00000000
04 3 1 00000054 20000054 00000000
05 0 0 00000054 00000000 20000054
05 1 0 00000024 00000000 20000024
05 2 0 00000034 00000000 20000034
05 3 0 00000044 00000000 20000044
06 2 1 00000200 3c000200 00000000
06 2 1 00000204 3c000204 00000000
06 2 1 00000208 3c000208 00000000
06 2 1 0000020c 3c00020c 00000000
06 2 1 00000210 3c000210 00000000
06 2 1 00000214 3c000214 00000000
06 3 1 00000004 5a5a0002 00000000
07 1 0 00000200 00000000 3c000200
07 1 0 00000204 00000000 3c000204
07 1 0 00000208 00000000 3c000208
07 1 0 0000020c 00000000 3c00020c
07 1 0 00000210 00000000 3c000210
07 1 0 00000214 00000000 3c000214
07 0 0 00000004 00000000 5a5a0002
ff 0 0 00000000 00000000 00000000

//--- tb.f
common/pool_pkg.sv
rtl/tcdm_bank.sv
interconnect/tcdm_arbiter.sv
interconnect/tcdm_xbar.sv
tile/tile_port.sv
rtl/pool_wrap.sv
verification/pool_checker.sv
verification/tb_pool.sv

//--- Makefile
SIM        := verilator
TOP        := tb_pool
FILELIST   := tb.f
SIM_FLAGS  := --binary --timing --assert --timescale 1ns/100ps -j 0
LINT_FLAGS := --lint-only -Wall --timing --timescale 1ns/100ps
BUILD_DIR  := obj_dir
LOG        := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^TEST PASS$$" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
